//--- verilog/usb_tx_pkg.sv
// ***********************************************************
// usb full speed transmit constants and PID codes
// all multi-bit fields go on the line lsb first
// ***********************************************************
package usb_tx_pkg;

  // field widths
  localparam int PID_W  = 8;
  localparam int SYNC_W = 8;
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;
  localparam int DATA_W = 64;

  // serializer bit counter has to reach the longest field
  localparam int BIT_CNT_W = $clog2(DATA_W);

  // packet shift register holds sync, pid and the widest payload
  localparam int PKT_SHIFT_W = DATA_W + PID_W + SYNC_W;
  localparam int TOKEN_PAD_W = DATA_W - ADDR_W - ENDP_W;

  // seven 0s and then a 1 when sent lsb first
  localparam logic [SYNC_W-1:0] SYNC_PATTERN = 8'b1000_0000;

  // token crc x^5+x^2+1
  localparam int                CRC5_W    = 5;
  localparam logic [CRC5_W-1:0] CRC5_POLY = 5'b0_0101;

  // data crc x^16+x^15+x^2+1
  localparam int                 CRC16_W    = 16;
  localparam logic [CRC16_W-1:0] CRC16_POLY = 16'h8005;

  // bit stuffing after this many 1s in a row
  localparam int STUFF_RUN   = 6;
  localparam int STUFF_CNT_W = $clog2(STUFF_RUN + 1);

  // end of packet is this many SE0 cycles then one J
  localparam int EOP_SE0_CYCLES = 2;
  localparam int EOP_CNT_W      = $clog2(EOP_SE0_CYCLES + 1);

  typedef enum logic [PID_W-1:0] {
    OUT   = 8'hE1,
    IN    = 8'h69,
    DATA0 = 8'hC3,
    ACK   = 8'hD2,
    NAK   = 8'h5A
  } pid_t;

endpackage : usb_tx_pkg

//--- verilog/usb_crc_gen.sv
// ***********************************************************
// serial crc, message bits go in msb of the remainder first
// emit must last exactly CRC_W shift cycles to refill with 1s
// ***********************************************************
`timescale 1ns/10ps

module usb_crc_gen #(
  parameter int               CRC_W = 5,
  parameter logic [CRC_W-1:0] POLY  = '0
) (
  input  logic clk,
  input  logic rst_L,
  input  logic clr,
  input  logic shift,
  input  logic emit,
  input  logic data_in,
  output logic crc_bit
);

  logic [CRC_W-1:0] rem;
  logic [CRC_W-1:0] rem_nxt;
  logic             fb;

  assign fb = rem[CRC_W-1] ^ data_in;

  always_comb begin
    if (emit) begin
      // shift the remainder out and back-fill with 1s
      rem_nxt = {rem[CRC_W-2:0], 1'b1};
    end else begin
      rem_nxt = {rem[CRC_W-2:0], 1'b0} ^ (fb ? POLY : '0);
    end
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      rem <= '1;
    end else if (clr) begin
      rem <= '1;
    end else if (shift) begin
      rem <= rem_nxt;
    end
  end

  // usb sends the ones complement of the remainder
  assign crc_bit = ~rem[CRC_W-1];

endmodule : usb_crc_gen

//--- verilog/usb_pkt_serializer.sv
// ***********************************************************
// one packet at a time, fields must hold until pkt_ready
// unknown pids go out as sync and pid only
// ***********************************************************
`timescale 1ns/10ps

module usb_pkt_serializer import usb_tx_pkg::*; (
  input  logic              clk,
  input  logic              rst_L,
  input  logic              pkt_valid,
  output logic              pkt_ready,
  input  pid_t              pkt_pid,
  input  logic [ADDR_W-1:0] pkt_addr,
  input  logic [ENDP_W-1:0] pkt_endp,
  input  logic [DATA_W-1:0] pkt_data,
  input  logic              stall,
  input  logic              tx_done,
  output logic              raw_valid,
  output logic              raw_bit,
  output logic              raw_last
);

  typedef enum logic [3:0] {
    IDLE, SYNC, PID, ADDR, ENDP, CRC5, DATA, CRC16, WAIT_DONE
  } ser_state_t;

  ser_state_t             state;
  pid_t                   pid_q;
  logic [PKT_SHIFT_W-1:0] shift_q;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic [BIT_CNT_W-1:0]   last_idx;
  logic                   accept;
  logic                   sending;
  logic                   shift_en;
  logic                   field_end;
  logic                   is_last;
  logic                   nxt_bit;
  logic                   crc5_shift;
  logic                   crc16_shift;
  logic                   crc5_bit;
  logic                   crc16_bit;

  assign pkt_ready = (state == IDLE);
  assign accept    = pkt_valid && pkt_ready;
  assign sending   = (state != IDLE) && (state != WAIT_DONE);
  assign shift_en  = state inside {SYNC, PID, ADDR, ENDP, DATA};

  // last bit index of the current field
  always_comb begin
    case (state)
      SYNC:    last_idx = BIT_CNT_W'(SYNC_W - 1);
      PID:     last_idx = BIT_CNT_W'(PID_W - 1);
      ADDR:    last_idx = BIT_CNT_W'(ADDR_W - 1);
      ENDP:    last_idx = BIT_CNT_W'(ENDP_W - 1);
      CRC5:    last_idx = BIT_CNT_W'(CRC5_W - 1);
      DATA:    last_idx = BIT_CNT_W'(DATA_W - 1);
      CRC16:   last_idx = BIT_CNT_W'(CRC16_W - 1);
      default: last_idx = '0;
    endcase
  end

  assign field_end = (bit_cnt == last_idx);

  // a packet closes on a crc end or on a bare pid
  always_comb begin
    is_last = 1'b0;
    if (field_end) begin
      case (state)
        CRC5, CRC16: is_last = 1'b1;
        PID:         is_last = !(pid_q inside {OUT, IN, DATA0});
        default:     is_last = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (state)
      CRC5:    nxt_bit = crc5_bit;
      CRC16:   nxt_bit = crc16_bit;
      default: nxt_bit = shift_q[0];
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      raw_valid <= 1'b0;
      raw_last  <= 1'b0;
    end else if (!stall) begin
      raw_valid <= sending;
      raw_last  <= is_last;
      bit_cnt   <= field_end ? '0 : bit_cnt + 1'b1;
      case (state)
        IDLE:      if (accept) state <= SYNC;
        SYNC:      if (field_end) state <= PID;
        PID: begin
          if (field_end) begin
            case (pid_q)
              OUT, IN: state <= ADDR;
              DATA0:   state <= DATA;
              default: state <= WAIT_DONE;
            endcase
          end
        end
        ADDR:      if (field_end) state <= ENDP;
        ENDP:      if (field_end) state <= CRC5;
        CRC5:      if (field_end) state <= WAIT_DONE;
        DATA:      if (field_end) state <= CRC16;
        CRC16:     if (field_end) state <= WAIT_DONE;
        WAIT_DONE: if (tx_done) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  // sync sits in the low bits so everything leaves lsb first
  always_ff @(posedge clk) begin
    if (accept) begin
      pid_q <= pkt_pid;
      if (pkt_pid == DATA0) begin
        shift_q <= {pkt_data, pkt_pid, SYNC_PATTERN};
      end else begin
        shift_q <= {{TOKEN_PAD_W{1'b0}}, pkt_endp, pkt_addr, pkt_pid, SYNC_PATTERN};
      end
    end else if (!stall && shift_en) begin
      shift_q <= shift_q >> 1;
    end
    if (!stall) begin
      raw_bit <= nxt_bit;
    end
  end

  assign crc5_shift  = !stall && (state inside {ADDR, ENDP, CRC5});
  assign crc16_shift = !stall && (state inside {DATA, CRC16});

  usb_crc_gen #(.CRC_W(CRC5_W), .POLY(CRC5_POLY)) u_crc5 (
    .clk     (clk),
    .rst_L   (rst_L),
    .clr     (accept),
    .shift   (crc5_shift),
    .emit    (state == CRC5),
    .data_in (shift_q[0]),
    .crc_bit (crc5_bit)
  );

  usb_crc_gen #(.CRC_W(CRC16_W), .POLY(CRC16_POLY)) u_crc16 (
    .clk     (clk),
    .rst_L   (rst_L),
    .clr     (accept),
    .shift   (crc16_shift),
    .emit    (state == CRC16),
    .data_in (shift_q[0]),
    .crc_bit (crc16_bit)
  );

endmodule : usb_pkt_serializer

//--- verilog/usb_bit_stuffer.sv
// ***********************************************************
// raw bits are taken only while stall is low
// ***********************************************************
`timescale 1ns/10ps

module usb_bit_stuffer import usb_tx_pkg::*; (
  input  logic clk,
  input  logic rst_L,
  input  logic raw_valid,
  input  logic raw_bit,
  input  logic raw_last,
  output logic stall,
  output logic line_valid,
  output logic line_bit,
  output logic line_last
);

  logic [STUFF_CNT_W-1:0] run_cnt;
  logic                   last_pend;
  logic                   run_done;

  // this 1 completes a run
  assign run_done = raw_bit && (run_cnt == STUFF_CNT_W'(STUFF_RUN - 1));

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      run_cnt    <= '0;
      stall      <= 1'b0;
      last_pend  <= 1'b0;
      line_valid <= 1'b0;
      line_last  <= 1'b0;
    end else if (stall) begin
      // stuffed 0 goes out, end marker moves onto it if pending
      run_cnt    <= '0;
      stall      <= 1'b0;
      last_pend  <= 1'b0;
      line_valid <= 1'b1;
      line_last  <= last_pend;
    end else if (raw_valid) begin
      line_valid <= 1'b1;
      if (run_done) begin
        run_cnt   <= '0;
        stall     <= 1'b1;
        last_pend <= raw_last;
        line_last <= 1'b0;
      end else begin
        run_cnt   <= raw_bit ? run_cnt + 1'b1 : '0;
        line_last <= raw_last;
      end
    end else begin
      run_cnt    <= '0;
      line_valid <= 1'b0;
      line_last  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    line_bit <= stall ? 1'b0 : raw_bit;
  end

endmodule : usb_bit_stuffer

//--- verilog/usb_line_driver.sv
// ***********************************************************
// expects an unbroken line_valid stream for the whole packet
// ***********************************************************
`timescale 1ns/10ps

module usb_line_driver import usb_tx_pkg::*; (
  input  logic clk,
  input  logic rst_L,
  input  logic line_valid,
  input  logic line_bit,
  input  logic line_last,
  output logic dp,
  output logic dm,
  output logic oe,
  output logic tx_done
);

  typedef enum logic [1:0] {
    IDLE, DATA, SE0, EOP_J
  } drv_state_t;

  drv_state_t           state;
  logic                 level;
  logic                 last_q;
  logic                 level_nxt;
  logic [EOP_CNT_W-1:0] se0_cnt;

  // nrzi, a 0 flips the line and a 1 keeps it
  assign level_nxt = line_bit ? level : ~level;

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      level   <= 1'b1;
      last_q  <= 1'b0;
      se0_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (line_valid) begin
            state  <= DATA;
            level  <= level_nxt;
            last_q <= line_last;
          end
        end
        DATA: begin
          if (last_q) begin
            // back to J so the next packet starts clean
            state   <= SE0;
            level   <= 1'b1;
            last_q  <= 1'b0;
            se0_cnt <= '0;
          end else if (line_valid) begin
            level  <= level_nxt;
            last_q <= line_last;
          end
        end
        SE0: begin
          if (se0_cnt == EOP_CNT_W'(EOP_SE0_CYCLES - 1)) begin
            state <= EOP_J;
          end else begin
            se0_cnt <= se0_cnt + 1'b1;
          end
        end
        EOP_J:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    oe      = (state != IDLE);
    tx_done = (state == EOP_J);
    // J unless sending data or SE0
    dp      = 1'b1;
    dm      = 1'b0;
    if (state == DATA) begin
      dp = level;
      dm = ~level;
    end else if (state == SE0) begin
      dp = 1'b0;
      dm = 1'b0;
    end
  end

endmodule : usb_line_driver

//--- verilog/usb_tx_top.sv
// ***********************************************************
// usb full speed host transmit path, dp/dm valid while oe high
// ***********************************************************
`timescale 1ns/10ps

module usb_tx_top import usb_tx_pkg::*; (
  input  logic              clk,
  input  logic              rst_L,
  input  logic              pkt_valid,
  output logic              pkt_ready,
  input  pid_t              pkt_pid,
  input  logic [ADDR_W-1:0] pkt_addr,
  input  logic [ENDP_W-1:0] pkt_endp,
  input  logic [DATA_W-1:0] pkt_data,
  output logic              dp,
  output logic              dm,
  output logic              oe,
  output logic              tx_done
);

  logic stall;
  logic raw_valid;
  logic raw_bit;
  logic raw_last;
  logic line_valid;
  logic line_bit;
  logic line_last;

  usb_pkt_serializer u_serializer (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_pid   (pkt_pid),
    .pkt_addr  (pkt_addr),
    .pkt_endp  (pkt_endp),
    .pkt_data  (pkt_data),
    .stall     (stall),
    .tx_done   (tx_done),
    .raw_valid (raw_valid),
    .raw_bit   (raw_bit),
    .raw_last  (raw_last)
  );

  usb_bit_stuffer u_stuffer (
    .clk        (clk),
    .rst_L      (rst_L),
    .raw_valid  (raw_valid),
    .raw_bit    (raw_bit),
    .raw_last   (raw_last),
    .stall      (stall),
    .line_valid (line_valid),
    .line_bit   (line_bit),
    .line_last  (line_last)
  );

  usb_line_driver u_line_driver (
    .clk        (clk),
    .rst_L      (rst_L),
    .line_valid (line_valid),
    .line_bit   (line_bit),
    .line_last  (line_last),
    .dp         (dp),
    .dm         (dm),
    .oe         (oe),
    .tx_done    (tx_done)
  );

endmodule : usb_tx_top

//--- tb/usb_tx_properties.sv
// ***********************************************************
// port rules of the transmit path, checked after reset only
// ***********************************************************
`timescale 1ns/10ps

module usb_tx_properties (
  input logic clk,
  input logic rst_L,
  input logic pkt_ready,
  input logic dp,
  input logic dm,
  input logic oe,
  input logic tx_done
);

  // no SE1 on the bus
  a_no_se1: assert property (@(posedge clk) disable iff (!rst_L)
    oe |-> !(dp && dm))
    else $error("dp and dm both high while oe is high");

  a_busy_while_oe: assert property (@(posedge clk) disable iff (!rst_L)
    oe |-> !pkt_ready)
    else $error("pkt_ready high while oe is high");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_L)
    tx_done |=> !tx_done)
    else $error("tx_done lasted more than one cycle");

  // line released right after the final J
  a_oe_falls: assert property (@(posedge clk) disable iff (!rst_L)
    tx_done |=> !oe)
    else $error("oe did not fall the cycle after tx_done");

endmodule : usb_tx_properties

bind usb_tx_top usb_tx_properties u_props (
  .clk       (clk),
  .rst_L     (rst_L),
  .pkt_ready (pkt_ready),
  .dp        (dp),
  .dm        (dm),
  .oe        (oe),
  .tx_done   (tx_done)
);

//--- tb/usb_tx_tb.sv
// ***********************************************************
// drives one packet at a time and checks every line cycle
// ***********************************************************
`timescale 1ns/10ps

module usb_tx_tb import usb_tx_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_PKTS   = 17;
  localparam int WAIT_LIMIT = 400;

  logic              clk;
  logic              rst_L;
  logic              pkt_valid;
  logic              pkt_ready;
  pid_t              pkt_pid;
  logic [ADDR_W-1:0] pkt_addr;
  logic [ENDP_W-1:0] pkt_endp;
  logic [DATA_W-1:0] pkt_data;
  logic              dp;
  logic              dm;
  logic              oe;
  logic              tx_done;

  // expected line cycles, {tx_done, dp, dm}
  logic [2:0]  exp_q[$];
  logic [2:0]  exp_e;
  logic [15:0] lfsr;
  int          err_cnt;
  int          chk_cnt;
  int          since_accept;
  logic        oe_prev;
  logic        done_prev;
  logic        busy;

  usb_tx_top u_dut (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .pkt_pid   (pkt_pid),
    .pkt_addr  (pkt_addr),
    .pkt_endp  (pkt_endp),
    .pkt_data  (pkt_data),
    .dp        (dp),
    .dm        (dm),
    .oe        (oe),
    .tx_done   (tx_done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois lfsr, one step per random bit
  function automatic logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = lfsr_step();
    return v;
  endfunction

  // one message bit into a usb crc of width w
  function automatic logic [15:0] crc_update(input logic [15:0] rem, input logic din,
                                             input logic [15:0] poly, input int w);
    logic        fb;
    logic [15:0] mask;
    mask = 16'((32'h1 << w) - 1);
    fb   = rem[w-1] ^ din;
    return ((rem << 1) ^ (fb ? poly : 16'h0)) & mask;
  endfunction

  // reference model, appends the expected line cycles of one packet
  function automatic void build_expected(input logic [7:0] pid, input logic [ADDR_W-1:0] addr,
                                         input logic [ENDP_W-1:0] endp,
                                         input logic [DATA_W-1:0] data);
    logic        raw[$];
    logic        stuffed[$];
    logic [15:0] crc;
    logic        level;
    int          run;
    for (int i = 0; i < SYNC_W; i++) raw.push_back(SYNC_PATTERN[i]);
    for (int i = 0; i < PID_W; i++) raw.push_back(pid[i]);
    if (pid == OUT || pid == IN) begin
      crc = '1;
      for (int i = 0; i < ADDR_W; i++) begin
        raw.push_back(addr[i]);
        crc = crc_update(crc, addr[i], 16'(CRC5_POLY), CRC5_W);
      end
      for (int i = 0; i < ENDP_W; i++) begin
        raw.push_back(endp[i]);
        crc = crc_update(crc, endp[i], 16'(CRC5_POLY), CRC5_W);
      end
      for (int i = CRC5_W - 1; i >= 0; i--) raw.push_back(~crc[i]);
    end else if (pid == DATA0) begin
      crc = '1;
      for (int i = 0; i < DATA_W; i++) begin
        raw.push_back(data[i]);
        crc = crc_update(crc, data[i], CRC16_POLY, CRC16_W);
      end
      for (int i = CRC16_W - 1; i >= 0; i--) raw.push_back(~crc[i]);
    end
    // a 0 goes in after every run of six 1s
    run = 0;
    foreach (raw[i]) begin
      stuffed.push_back(raw[i]);
      run = raw[i] ? run + 1 : 0;
      if (run == STUFF_RUN) begin
        stuffed.push_back(1'b0);
        run = 0;
      end
    end
    // nrzi from J, a 0 toggles
    level = 1'b1;
    foreach (stuffed[i]) begin
      if (!stuffed[i]) level = ~level;
      exp_q.push_back({1'b0, level, ~level});
    end
    for (int i = 0; i < EOP_SE0_CYCLES; i++) exp_q.push_back(3'b000);
    exp_q.push_back(3'b110);
  endfunction

  // called on a rising edge, returns on the accept edge
  task automatic send_packet(input logic [7:0] pid, input logic [ADDR_W-1:0] addr,
                             input logic [ENDP_W-1:0] endp, input logic [DATA_W-1:0] data,
                             input bit hold);
    int n;
    n = 0;
    pkt_valid <= 1'b1;
    pkt_pid   <= pid_t'(pid);
    pkt_addr  <= addr;
    pkt_endp  <= endp;
    pkt_data  <= data;
    do begin
      @(posedge clk);
      n++;
    end while (!pkt_ready && n < WAIT_LIMIT);
    assert (pkt_ready) else begin
      $display("packet with pid %h was never accepted", pid);
      err_cnt++;
    end
    build_expected(pid, addr, endp, data);
    if (!hold) pkt_valid <= 1'b0;
  endtask

  task automatic wait_tx_done();
    int n;
    n = 0;
    while (!tx_done && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    assert (tx_done) else begin
      $display("tx_done never came at %0t", $time);
      err_cnt++;
    end
  endtask

  task automatic send_token(input logic [7:0] pid);
    send_packet(pid, ADDR_W'(random_bits(ADDR_W)), ENDP_W'(random_bits(ENDP_W)), '0, 1'b0);
    wait_tx_done();
  endtask

  // comparing process, samples in the middle of each cycle
  always @(negedge clk) begin
    if (rst_L) begin
      if (done_prev) begin
        assert (!oe) else begin
          $display("oe still high the cycle after tx_done at %0t", $time);
          err_cnt++;
        end
      end
      if (oe) begin
        if (!oe_prev) begin
          assert (since_accept == 3) else begin
            $display("FAIL t=%0t oe_delay got %0d exp 3", $time, since_accept);
            err_cnt++;
          end
        end
        assert (exp_q.size() != 0) else begin
          $display("line active at %0t with no packet expected", $time);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          exp_e = exp_q.pop_front();
          chk_cnt++;
          assert ({dp, dm} == exp_e[1:0]) else begin
            $display("FAIL t=%0t dp_dm got %b exp %b", $time, {dp, dm}, exp_e[1:0]);
            err_cnt++;
          end
          assert (tx_done == exp_e[2]) else begin
            $display("FAIL t=%0t tx_done got %b exp %b", $time, tx_done, exp_e[2]);
            err_cnt++;
          end
        end
      end else begin
        assert (!tx_done) else begin
          $display("tx_done pulsed with oe low at %0t", $time);
          err_cnt++;
        end
        // released line rests in J
        assert ({dp, dm} == 2'b10) else begin
          $display("FAIL t=%0t dp_dm got %b exp %b", $time, {dp, dm}, 2'b10);
          err_cnt++;
        end
      end
      if (tx_done) busy = 1'b0;
      // accept happens on the coming rising edge
      if (pkt_valid && pkt_ready) begin
        assert (!busy) else begin
          $display("packet accepted before the previous tx_done at %0t", $time);
          err_cnt++;
        end
        busy         = 1'b1;
        since_accept = 0;
      end else if (since_accept < 1000) begin
        since_accept++;
      end
      oe_prev   = oe;
      done_prev = tx_done;
    end
  end

  // watchdog
  initial begin
    #(2 * NUM_PKTS * 150 * CLK_PERIOD);
    $display("run stopped by watchdog, DUT did not finish");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_L        = 1'b0;
    pkt_valid    = 1'b0;
    pkt_pid      = ACK;
    pkt_addr     = '0;
    pkt_endp     = '0;
    pkt_data     = '0;
    lfsr         = 16'd49610;
    err_cnt      = 0;
    chk_cnt      = 0;
    since_accept = 1000;
    oe_prev      = 1'b0;
    done_prev    = 1'b0;
    busy         = 1'b0;
    repeat (3) @(posedge clk);
    rst_L <= 1'b1;
    @(negedge clk);
    assert (pkt_ready && !oe && !tx_done) else begin
      $display("idle state after reset is wrong");
      err_cnt++;
    end
    @(posedge clk);

    // tokens
    for (int i = 0; i < 3; i++) send_token(OUT);
    for (int i = 0; i < 3; i++) send_token(IN);

    // data packets, random and all ones
    for (int i = 0; i < 3; i++) begin
      send_packet(DATA0, '0, '0, random_bits(DATA_W), 1'b0);
      wait_tx_done();
    end
    send_packet(DATA0, '0, '0, '1, 1'b0);
    wait_tx_done();

    // pid only, the last one is not a known code
    send_token(ACK);
    send_token(NAK);
    send_token(8'h3C);

    // valid held high across four packets
    send_packet(OUT, ADDR_W'(random_bits(ADDR_W)), ENDP_W'(random_bits(ENDP_W)), '0, 1'b1);
    send_packet(DATA0, '0, '0, random_bits(DATA_W), 1'b1);
    send_packet(ACK, '0, '0, '0, 1'b1);
    send_packet(IN, ADDR_W'(random_bits(ADDR_W)), ENDP_W'(random_bits(ENDP_W)), '0, 1'b0);
    wait_tx_done();
    repeat (4) @(posedge clk);

    assert (exp_q.size() == 0) else begin
      $display("%0d expected line cycles never appeared", exp_q.size());
      err_cnt++;
    end
    $display("line checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : usb_tx_tb

//--- sources.f
verilog/usb_tx_pkg.sv
verilog/usb_crc_gen.sv
verilog/usb_pkt_serializer.sv
verilog/usb_bit_stuffer.sv
verilog/usb_line_driver.sv
verilog/usb_tx_top.sv
tb/usb_tx_properties.sv
tb/usb_tx_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = usb_tx_tb
FILELIST = sources.f

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
